// File: compile.f
source/cop_types_pkg.sv
source/cop_isa_pkg.sv
source/cop_lane_if.sv
source/cop_cprs.sv
source/cop_decode.sv
source/cop_palu_lane.sv
source/cop_writeback.sv
source/cop_core.sv
bench/cop_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall
TOP       := cop_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/cop_tb.sv
`default_nettype none

// Random instruction run of the core against a register model
module cop_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam cop_types_pkg::creg_data_t RESET_VALUE = 32'h3c5a_96e1;  // Nonzero reset pattern
    localparam int N_RESET = 16;
    localparam int N_LOAD  = 32;
    localparam int N_RAND  = 300;
    localparam int N_MASK  = 32;
    localparam int N_HAZ   = 40;
    localparam int N_ORDER = 32;
    localparam int N_TOTAL = N_RESET + N_LOAD + N_RAND + N_MASK + N_HAZ + N_ORDER;
    localparam int CYCLE_LIMIT = 3 * N_TOTAL + 100;

    logic                      g_clk;
    logic                      g_resetn;
    logic                      insn_valid;
    cop_isa_pkg::cop_op_t      insn_op;
    cop_types_pkg::creg_addr_t insn_rs1;
    cop_types_pkg::creg_addr_t insn_rs2;
    cop_types_pkg::creg_addr_t insn_rs3;
    cop_types_pkg::creg_addr_t insn_rd;
    cop_types_pkg::byte_mask_t insn_wen;
    logic                      stall;
    logic                      rd_valid;
    cop_types_pkg::creg_addr_t rd_addr;
    cop_types_pkg::creg_data_t rd_data;
    cop_types_pkg::byte_mask_t rd_wen;

    // Model state updated in program order at acceptance
    cop_types_pkg::creg_data_t model_regs [16];
    cop_types_pkg::creg_addr_t exp_addr_q [$];
    cop_types_pkg::creg_data_t exp_data_q [$];
    cop_types_pkg::byte_mask_t exp_mask_q [$];

    logic [31:0] seed = 32'hfdd9_d251;
    int error_count    = 0;
    int accepted_count = 0;
    int result_count   = 0;
    int stall_count    = 0;    // Cycles an offer was held
    int test_errors    = 0;
    int test_accepts   = 0;
    int cycle_count;

    cop_core #(.CPRS_RESET(RESET_VALUE)) u_dut (
        .g_clk, .g_resetn,
        .insn_valid, .insn_op, .insn_rs1, .insn_rs2, .insn_rs3, .insn_rd, .insn_wen,
        .stall,
        .rd_valid, .rd_addr, .rd_data, .rd_wen
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;   // 8 ns period
    end

    // Cycle budget that ends a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge g_clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    // LCG with the Numerical Recipes constants
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic cop_types_pkg::creg_addr_t to_addr(input int v);
        return cop_types_pkg::creg_addr_t'(v);   // Wraps mod 16
    endfunction

    // Per-byte lane rules applied across a whole word
    function automatic cop_types_pkg::creg_data_t model_result(
        input cop_isa_pkg::cop_op_t op, input cop_types_pkg::creg_data_t s1,
        input cop_types_pkg::creg_data_t s2, input cop_types_pkg::creg_data_t s3);
        cop_types_pkg::creg_data_t w;
        cop_types_pkg::lane_byte_t a;
        cop_types_pkg::lane_byte_t b;
        cop_types_pkg::lane_byte_t c;
        int sh;
        for (int n = 0; n < cop_types_pkg::NUM_LANES; n++) begin
            a  = s1[8*n +: 8];
            b  = s2[8*n +: 8];
            c  = s3[8*n +: 8];
            sh = {29'd0, b[2:0]};
            case (op)
                cop_isa_pkg::OP_ADD: w[8*n +: 8] = a + b;
                cop_isa_pkg::OP_SUB: w[8*n +: 8] = a - b;
                cop_isa_pkg::OP_XOR: w[8*n +: 8] = a ^ b;
                cop_isa_pkg::OP_ROL: w[8*n +: 8] = (a << sh) | (a >> (8 - sh));
                cop_isa_pkg::OP_MIX: w[8*n +: 8] = a ^ (b & c);
                default:             w[8*n +: 8] = a;   // Move and codes 6 and 7
            endcase
        end
        return w;
    endfunction

    task automatic check_data(input string name, input cop_types_pkg::creg_data_t got,
                              input cop_types_pkg::creg_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input cop_types_pkg::creg_addr_t got,
                              input cop_types_pkg::creg_addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_mask(input string name, input cop_types_pkg::byte_mask_t got,
                              input cop_types_pkg::byte_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Registered outputs sampled mid cycle
    always @(negedge g_clk) begin
        if (g_resetn && rd_valid) begin
            result_count++;
            if (exp_data_q.size() == 0) begin
                $display("Result reported at %0d ns with nothing outstanding", $time);
                error_count++;
            end else begin
                check_addr("rd_addr", rd_addr, exp_addr_q.pop_front());
                check_data("rd_data", rd_data, exp_data_q.pop_front());
                check_mask("rd_wen", rd_wen, exp_mask_q.pop_front());
            end
        end
    end

    // Starts at a falling edge and returns at the falling edge after acceptance
    task automatic issue(input cop_isa_pkg::cop_op_t op, input cop_types_pkg::creg_addr_t rs1,
                         input cop_types_pkg::creg_addr_t rs2, input cop_types_pkg::creg_addr_t rs3,
                         input cop_types_pkg::creg_addr_t rd, input cop_types_pkg::byte_mask_t wen);
        cop_types_pkg::creg_data_t res;
        insn_valid = 1'b1;
        insn_op    = op;
        insn_rs1   = rs1;
        insn_rs2   = rs2;
        insn_rs3   = rs3;
        insn_rd    = rd;
        insn_wen   = wen;
        #1;                         // Let stall settle
        while (stall) begin
            stall_count++;
            @(negedge g_clk);       // Hold the offer
            #1;
        end
        res = model_result(op, model_regs[rs1], model_regs[rs2], model_regs[rs3]);
        for (int n = 0; n < cop_types_pkg::NUM_LANES; n++) begin
            if (wen[n]) begin
                model_regs[rd][8*n +: 8] = res[8*n +: 8];   // Masked merge
            end
        end
        exp_addr_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_mask_q.push_back(wen);
        accepted_count++;
        @(negedge g_clk);
    endtask

    task automatic end_test(input string name);
        insn_valid = 1'b0;
        while (exp_data_q.size() != 0) begin
            @(negedge g_clk);       // Wait for outstanding results
        end
        $display("Test %s: %0d instructions, %0d errors", name,
                 accepted_count - test_accepts, error_count - test_errors);
        test_accepts = accepted_count;
        test_errors  = error_count;
    endtask

    initial begin
        logic [31:0]               r;
        cop_types_pkg::creg_addr_t prev;
        int                        stalls_before;
        g_resetn   = 1'b0;
        insn_valid = 1'b0;
        insn_op    = '0;
        insn_rs1   = '0;
        insn_rs2   = '0;
        insn_rs3   = '0;
        insn_rd    = '0;
        insn_wen   = '0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = RESET_VALUE;
        end
        repeat (5) @(posedge g_clk);   // Five reset edges
        @(negedge g_clk);
        g_resetn = 1'b1;

        for (int i = 0; i < N_RESET; i++) begin   // Each register onto itself
            issue(cop_isa_pkg::OP_MOV, to_addr(i), 4'd0, 4'd0, to_addr(i), 4'hf);
        end
        end_test("reset");

        // Add chain then rotates to spread distinct values
        for (int i = 0; i < 16; i++) begin
            issue(cop_isa_pkg::OP_ADD, to_addr(i + 15), to_addr(i), 4'd0, to_addr(i), 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            issue(cop_isa_pkg::OP_ROL, to_addr(i), to_addr(i + 5), 4'd0, to_addr(i), 4'hf);
        end
        end_test("load");

        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            issue(r[30:28], r[27:24], r[23:20], r[19:16], r[15:12], r[11:8]);
        end
        end_test("random");

        for (int i = 0; i < 16; i++) begin   // Partial masks from 1 to 14
            r = next_rand();
            issue(r[30:28], r[27:24], r[23:20], r[19:16], to_addr(i),
                  cop_types_pkg::byte_mask_t'(1 + r[11:8] % 14));
        end
        for (int i = 0; i < 16; i++) begin   // Read back all bytes
            issue(cop_isa_pkg::OP_MOV, to_addr(i), 4'd0, 4'd0, to_addr(i), 4'hf);
        end
        end_test("mask");

        prev          = 4'd3;
        stalls_before = stall_count;
        for (int i = 0; i < N_HAZ; i++) begin   // Every source is the last destination
            r = next_rand();
            issue(r[30:28], prev, prev, prev, r[15:12], r[11:8]);
            prev = r[15:12];
        end
        if (stall_count == stalls_before) begin
            $display("Dependent chain ran without a single stall");
            error_count++;
        end
        end_test("hazard");

        stalls_before = stall_count;
        for (int i = 0; i < N_ORDER; i++) begin   // Sources in 0 to 7 and destinations in 8 to 15
            r = next_rand();
            issue(r[30:28], {1'b0, r[26:24]}, {1'b0, r[22:20]}, {1'b0, r[18:16]},
                  to_addr(8 + i % 8), r[11:8]);
        end
        if (stall_count != stalls_before) begin
            $display("Independent instructions stalled for %0d cycles",
                     stall_count - stalls_before);
            error_count++;
        end
        end_test("order");

        if (result_count != accepted_count) begin
            $display("Result count %0d does not match accepted count %0d",
                     result_count, accepted_count);
            error_count++;
        end
        $display("Summary: %0d accepted, %0d results, %0d errors",
                 accepted_count, result_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cop_core.sv
`default_nettype none

// Coprocessor arithmetic core, two cycle issue to result
module cop_core #(
    parameter cop_types_pkg::creg_data_t CPRS_RESET = '0
) (
    input  wire                             g_clk,
    input  wire                             g_resetn,

    input  wire                             insn_valid,
    input  wire cop_isa_pkg::cop_op_t       insn_op,
    input  wire cop_types_pkg::creg_addr_t  insn_rs1,
    input  wire cop_types_pkg::creg_addr_t  insn_rs2,
    input  wire cop_types_pkg::creg_addr_t  insn_rs3,
    input  wire cop_types_pkg::creg_addr_t  insn_rd,
    input  wire cop_types_pkg::byte_mask_t  insn_wen,
    output logic                            stall,

    output logic                            rd_valid,
    output cop_types_pkg::creg_addr_t       rd_addr,
    output cop_types_pkg::creg_data_t       rd_data,
    output cop_types_pkg::byte_mask_t       rd_wen
);

    // Read side
    logic                      crs1_ren;
    logic                      crs2_ren;
    logic                      crs3_ren;
    cop_types_pkg::creg_addr_t crs1_addr;
    cop_types_pkg::creg_addr_t crs2_addr;
    cop_types_pkg::creg_addr_t crs3_addr;
    cop_types_pkg::creg_data_t crs1_rdata;
    cop_types_pkg::creg_data_t crs2_rdata;
    cop_types_pkg::creg_data_t crs3_rdata;

    // Write side
    cop_types_pkg::byte_mask_t crd_wen;
    cop_types_pkg::creg_addr_t crd_addr;
    cop_types_pkg::creg_data_t crd_wdata;

    logic                      wb_valid;     // Stage 2 tag
    cop_types_pkg::creg_addr_t wb_addr;
    cop_types_pkg::byte_mask_t wb_mask;
    cop_types_pkg::lane_byte_t lane_result [cop_types_pkg::NUM_LANES];

    cop_lane_if lane_if [cop_types_pkg::NUM_LANES] ();

    cop_decode u_decode (
        .g_clk, .g_resetn,
        .insn_valid, .insn_op, .insn_rs1, .insn_rs2, .insn_rs3, .insn_rd, .insn_wen,
        .stall,
        .crs1_ren, .crs2_ren, .crs3_ren,
        .crs1_addr, .crs2_addr, .crs3_addr,
        .crs1_rdata, .crs2_rdata, .crs3_rdata,
        .lanes (lane_if),
        .wb_valid, .wb_addr, .wb_mask
    );

    cop_cprs #(.CPRS_RESET(CPRS_RESET)) u_cprs (
        .g_clk, .g_resetn,
        .crs1_ren, .crs1_addr, .crs1_rdata,
        .crs2_ren, .crs2_addr, .crs2_rdata,
        .crs3_ren, .crs3_addr, .crs3_rdata,
        .crd_wen, .crd_addr, .crd_wdata
    );

    // One ALU per byte
    for (genvar i = 0; i < cop_types_pkg::NUM_LANES; i++) begin : g_lane
        cop_palu_lane u_lane (
            .g_clk, .g_resetn,
            .lane   (lane_if[i]),
            .result (lane_result[i])
        );
    end

    cop_writeback u_writeback (
        .g_clk, .g_resetn,
        .lane_bytes (lane_result),
        .wb_valid, .wb_addr, .wb_mask,
        .crd_wen, .crd_addr, .crd_wdata,
        .rd_valid, .rd_addr, .rd_data, .rd_wen
    );

endmodule

`default_nettype wire

// File: source/cop_writeback.sv
`default_nettype none

// Stage 2: merge lane bytes, write the register file, report the result
module cop_writeback (
    input  wire                             g_clk,
    input  wire                             g_resetn,

    input  wire cop_types_pkg::lane_byte_t  lane_bytes [cop_types_pkg::NUM_LANES],

    input  wire                             wb_valid,
    input  wire cop_types_pkg::creg_addr_t  wb_addr,
    input  wire cop_types_pkg::byte_mask_t  wb_mask,

    output cop_types_pkg::byte_mask_t       crd_wen,
    output cop_types_pkg::creg_addr_t       crd_addr,
    output cop_types_pkg::creg_data_t       crd_wdata,

    output logic                            rd_valid,
    output cop_types_pkg::creg_addr_t       rd_addr,
    output cop_types_pkg::creg_data_t       rd_data,    // Full result, all bytes
    output cop_types_pkg::byte_mask_t       rd_wen
);

    // Lane n fills byte n
    always_comb begin
        for (int n = 0; n < cop_types_pkg::NUM_LANES; n++) begin
            crd_wdata[8*n +: 8] = lane_bytes[n];
        end
    end

    assign crd_wen  = wb_mask & {cop_types_pkg::NUM_LANES{wb_valid}};   // Idle lanes never write
    assign crd_addr = wb_addr;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= wb_valid;
        end
    end

    // Report fields, meaningful with rd_valid
    always_ff @(posedge g_clk) begin
        rd_addr <= crd_addr;
        rd_data <= crd_wdata;
        rd_wen  <= crd_wen;
    end

    // Empty slot writes nothing and reports nothing
    a_idle_quiet : assert property (@(posedge g_clk) disable iff (!g_resetn)
        !wb_valid |-> (crd_wen == '0) ##1 !rd_valid);

endmodule

`default_nettype wire

// File: source/cop_palu_lane.sv
`default_nettype none

// Byte ALU for one lane, result registered
module cop_palu_lane (
    input  wire                  g_clk,
    input  wire                  g_resetn,
    cop_lane_if.lane             lane,
    output cop_types_pkg::lane_byte_t result
);

    logic [15:0]               rol_word;   // Byte doubled so the shift wraps
    cop_types_pkg::lane_byte_t rol_byte;
    cop_types_pkg::lane_byte_t next_byte;

    // Rotate amount from low 3 bits of src2
    assign rol_word = {lane.a, lane.a} << lane.b[2:0];
    assign rol_byte = rol_word[15:8];

    always_comb begin
        case (lane.op)
            cop_isa_pkg::OP_ADD: next_byte = lane.a + lane.b;   // Carry dropped
            cop_isa_pkg::OP_SUB: next_byte = lane.a - lane.b;
            cop_isa_pkg::OP_XOR: next_byte = lane.a ^ lane.b;
            cop_isa_pkg::OP_ROL: next_byte = rol_byte;
            cop_isa_pkg::OP_MIX: next_byte = lane.a ^ (lane.b & lane.c);
            cop_isa_pkg::OP_MOV: next_byte = lane.a;
            default:             next_byte = lane.a;            // Codes 6, 7
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            result <= '0;
        end else begin
            result <= next_byte;
        end
    end

endmodule

`default_nettype wire

// File: source/cop_decode.sv
`default_nettype none

// Stages 0 and 1 take an instruction, check hazards and read operands into lanes
module cop_decode (
    input  wire                             g_clk,
    input  wire                             g_resetn,

    input  wire                             insn_valid,
    input  wire cop_isa_pkg::cop_op_t       insn_op,
    input  wire cop_types_pkg::creg_addr_t  insn_rs1,
    input  wire cop_types_pkg::creg_addr_t  insn_rs2,
    input  wire cop_types_pkg::creg_addr_t  insn_rs3,
    input  wire cop_types_pkg::creg_addr_t  insn_rd,
    input  wire cop_types_pkg::byte_mask_t  insn_wen,
    output logic                            stall,      // Hold the offered instruction

    output logic                            crs1_ren,
    output logic                            crs2_ren,
    output logic                            crs3_ren,
    output cop_types_pkg::creg_addr_t       crs1_addr,
    output cop_types_pkg::creg_addr_t       crs2_addr,
    output cop_types_pkg::creg_addr_t       crs3_addr,
    input  wire cop_types_pkg::creg_data_t  crs1_rdata,
    input  wire cop_types_pkg::creg_data_t  crs2_rdata,
    input  wire cop_types_pkg::creg_data_t  crs3_rdata,

    cop_lane_if.feed                        lanes [cop_types_pkg::NUM_LANES],

    output logic                            wb_valid,   // Stage 2 tag
    output cop_types_pkg::creg_addr_t       wb_addr,
    output cop_types_pkg::byte_mask_t       wb_mask
);

    logic                      uses_rs2;    // All but move
    logic                      uses_rs3;    // Mix only
    logic                      hit_rs1;
    logic                      hit_rs2;
    logic                      hit_rs3;
    logic                      accept;
    logic                      s1_valid;    // Stage 1 tag while lanes hold operands
    cop_types_pkg::creg_addr_t s1_rd;
    cop_types_pkg::byte_mask_t s1_mask;

    // Move and the spare codes read src1 only
    assign uses_rs2 = insn_op inside {cop_isa_pkg::OP_ADD, cop_isa_pkg::OP_SUB,
                                      cop_isa_pkg::OP_XOR, cop_isa_pkg::OP_ROL,
                                      cop_isa_pkg::OP_MIX};
    assign uses_rs3 = (insn_op == cop_isa_pkg::OP_MIX);

    // Source matches a destination still in flight
    assign hit_rs1 = (s1_valid && s1_rd == insn_rs1) || (wb_valid && wb_addr == insn_rs1);
    assign hit_rs2 = (s1_valid && s1_rd == insn_rs2) || (wb_valid && wb_addr == insn_rs2);
    assign hit_rs3 = (s1_valid && s1_rd == insn_rs3) || (wb_valid && wb_addr == insn_rs3);

    assign stall  = insn_valid && (hit_rs1 || (uses_rs2 && hit_rs2) || (uses_rs3 && hit_rs3));
    assign accept = insn_valid && !stall;

    // Operands read in the offer cycle
    assign crs1_ren  = insn_valid;
    assign crs2_ren  = insn_valid && uses_rs2;
    assign crs3_ren  = insn_valid && uses_rs3;
    assign crs1_addr = insn_rs1;
    assign crs2_addr = insn_rs2;
    assign crs3_addr = insn_rs3;

    // Byte n of each word goes to lane n
    for (genvar i = 0; i < cop_types_pkg::NUM_LANES; i++) begin : g_feed
        always_ff @(posedge g_clk) begin
            if (accept) begin
                lanes[i].a  <= crs1_rdata[8*i +: 8];
                lanes[i].b  <= crs2_rdata[8*i +: 8];
                lanes[i].c  <= crs3_rdata[8*i +: 8];
                lanes[i].op <= insn_op;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            wb_valid <= s1_valid;   // Lanes take one cycle
        end
    end

    // Tag payload beside the valids above
    always_ff @(posedge g_clk) begin
        if (accept) begin
            s1_rd   <= insn_rd;
            s1_mask <= insn_wen;
        end
        wb_addr <= s1_rd;
        wb_mask <= s1_mask;
    end

    // Every op reads src1, so a pending write to it keeps the op out of stage 1
    a_rs1_hazard_held : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (insn_valid && ((s1_valid && s1_rd == insn_rs1) || (wb_valid && wb_addr == insn_rs1)))
            |=> !s1_valid);

endmodule

`default_nettype wire

// File: source/cop_cprs.sv
`default_nettype none

// Sixteen word register file, 3 read ports, 1 byte-masked write port
module cop_cprs #(
    parameter cop_types_pkg::creg_data_t CPRS_RESET = '0  // Reset value of all regs
) (
    input  wire                             g_clk,
    input  wire                             g_resetn,

    input  wire                             crs1_ren,
    input  wire cop_types_pkg::creg_addr_t  crs1_addr,
    output cop_types_pkg::creg_data_t       crs1_rdata,

    input  wire                             crs2_ren,
    input  wire cop_types_pkg::creg_addr_t  crs2_addr,
    output cop_types_pkg::creg_data_t       crs2_rdata,

    input  wire                             crs3_ren,
    input  wire cop_types_pkg::creg_addr_t  crs3_addr,
    output cop_types_pkg::creg_data_t       crs3_rdata,

    input  wire cop_types_pkg::byte_mask_t  crd_wen,    // Per-byte write enable
    input  wire cop_types_pkg::creg_addr_t  crd_addr,
    input  wire cop_types_pkg::creg_data_t  crd_wdata
);

    // One register per address value
    localparam int NUM_REGS = 2 ** $bits(cop_types_pkg::creg_addr_t);

    cop_types_pkg::creg_data_t regs [NUM_REGS];

    // Disabled ports read as zero
    assign crs1_rdata = crs1_ren ? regs[crs1_addr] : '0;
    assign crs2_rdata = crs2_ren ? regs[crs2_addr] : '0;
    assign crs3_rdata = crs3_ren ? regs[crs3_addr] : '0;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= CPRS_RESET;
            end
        end else if (|crd_wen) begin
            // Only the enabled bytes change, others keep old value
            for (int n = 0; n < cop_types_pkg::NUM_LANES; n++) begin
                if (crd_wen[n]) begin
                    regs[crd_addr][8*n +: 8] <= crd_wdata[8*n +: 8];
                end
            end
        end
    end

    // Every register left reset with a known value, so reads stay clean
    a_rdata_known : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (crs1_ren || crs2_ren || crs3_ren) |->
            !$isunknown({crs1_rdata, crs2_rdata, crs3_rdata}));

endmodule

`default_nettype wire

// File: source/cop_lane_if.sv
`default_nettype none

// Operands and opcode of one byte lane, held for a cycle in stage 1
interface cop_lane_if;

    cop_types_pkg::lane_byte_t a;   // Source 1 byte
    cop_types_pkg::lane_byte_t b;   // Source 2 byte
    cop_types_pkg::lane_byte_t c;   // Source 3 byte
    cop_isa_pkg::cop_op_t      op;  // Same code in every lane

    // Decode side
    modport feed (
        output a, b, c, op
    );

    // ALU side
    modport lane (
        input a, b, c, op
    );

endinterface

`default_nettype wire

// File: source/cop_isa_pkg.sv
`default_nettype none

// Lane operation encodings
package cop_isa_pkg;

    typedef logic [2:0] cop_op_t;  // Operation code field

    localparam cop_op_t OP_ADD = 3'd0;  // Byte add, wraps
    localparam cop_op_t OP_SUB = 3'd1;  // Byte subtract
    localparam cop_op_t OP_XOR = 3'd2;
    // Rotate src1 byte left by low 3 bits of src2 byte
    localparam cop_op_t OP_ROL = 3'd3;
    // src1 ^ (src2 & src3), the only 3-source op
    localparam cop_op_t OP_MIX = 3'd4;
    localparam cop_op_t OP_MOV = 3'd5;  // Copy of src1

    // Codes 6 and 7 are unassigned and behave as move

endpackage

`default_nettype wire

// File: source/cop_types_pkg.sv
`default_nettype none

// Widths shared by the datapath blocks
package cop_types_pkg;

    // Four byte lanes make up one register word
    localparam int NUM_LANES = 4;

    // Register address, sixteen registers
    typedef logic [3:0] creg_addr_t;

    typedef logic [31:0] creg_data_t;  // Full register word

    typedef logic [7:0] lane_byte_t;   // Byte handled by one lane

    // Bit n enables write of byte n
    typedef logic [NUM_LANES-1:0] byte_mask_t;

endpackage

`default_nettype wire
